/* adc_cal_top.f */
+incdir+logic
logic/adc_cal_pkg.sv
logic/calibration_fsm.sv
logic/phase_shift_counter.sv
logic/clock_edge_sampler.sv
logic/valid_phase_record.sv
logic/adc_cal_top.sv
testbench/adc_cal_properties.sv
testbench/adc_cal_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS := --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
TOP := adc_cal_tb
FILELIST := adc_cal_top.f
OBJ_DIR := obj_dir
LOG := sim.log
PASS_MSG := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/adc_cal_tests.txt */
# name  edge_phase  peak_ps_count  newest_entry
# edge phase and peak count are decimal, newest entry is the hex low byte of the saved count
phase_min        2    2    02
phase_three      3    3    03
phase_seven      7    7    07
phase_mid        37   37   25
phase_half_byte  128  128  80
phase_byte_top   255  255  ff
phase_wrap       256  256  00
phase_wrap_plus  300  300  2c
phase_at_max     600  600  58
phase_past_max   610  600  58
phase_small      9    9    09
phase_four       4    4    04

/* testbench/adc_cal_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_cal_defs.svh"

module adc_cal_tb;

	import adc_cal_pkg::*;

	localparam int CLK_HALF = 10;
	localparam int DRIVE_DELAY = 1;
	localparam int STALL_LIMIT = 64;

	typedef logic [8*16-1:0] test_name_t;

	logic dcm_psclk;
	logic ctrl_reset;
	logic adc0_locked;
	logic adc1_locked;
	logic psdone;
	logic adc1_clk_level;
	dcm_status_t dcm_status;
	cal_ctrl_t cal_ctrl;
	cal_state_t sync_state;
	logic [`CAL_PS_WIDTH-1:0] ps_count;
	logic [`CAL_REC_WIDTH*`CAL_REC_DEPTH-1:0] valid_ps_counts;

	int psen_count; // steps since the last DCM reset, as the DCM sees them
	int edge_phase;
	int value_errors;
	int other_errors;
	logic [`CAL_REC_WIDTH-1:0] exp_rec [`CAL_REC_DEPTH];

	assign dcm_status = {adc0_locked, adc1_locked, psdone};

	adc_cal_top adc_cal_top_inst (
		.dcm_psclk(dcm_psclk),
		.ctrl_reset(ctrl_reset),
		.dcm_status(dcm_status),
		.adc1_clk_level(adc1_clk_level),
		.cal_ctrl(cal_ctrl),
		.sync_state(sync_state),
		.ps_count(ps_count),
		.valid_ps_counts(valid_ps_counts)
	);

	bind calibration_fsm adc_cal_properties adc_cal_properties_inst (
		.dcm_psclk(dcm_psclk),
		.ctrl_reset(ctrl_reset),
		.sync_state(sync_state),
		.cal_ctrl(cal_ctrl),
		.phase_save_en(phase_save_en)
	);

	initial begin
		dcm_psclk = 1'b0;
		forever #(CLK_HALF) dcm_psclk = ~dcm_psclk;
	end

	// second DCM and its ADC, updated just after each rising edge
	initial begin : dcm_model
		int psdone_timer;
		int lock_fall_timer;
		int lock_rise_timer;
		logic prev_adc1_reset;
		adc1_locked = 1'b1;
		psdone = 1'b0;
		adc1_clk_level = 1'b0;
		psen_count = 0;
		psdone_timer = 0;
		lock_fall_timer = 0;
		lock_rise_timer = 0;
		prev_adc1_reset = 1'b0;
		forever begin
			@(posedge dcm_psclk);
			#(DRIVE_DELAY);
			psdone = 1'b0;
			if (psdone_timer != 0) begin
				psdone_timer = psdone_timer - 1;
				psdone = (psdone_timer == 0);
			end
			if (cal_ctrl.psen) begin
				psen_count = psen_count + 1;
				psdone_timer = 2 + int'($urandom % 8);
			end
			if (lock_fall_timer != 0) begin
				lock_fall_timer = lock_fall_timer - 1;
				if (lock_fall_timer == 0) begin
					adc1_locked = 1'b0;
				end
			end
			if (cal_ctrl.adc1_reset && !prev_adc1_reset) begin
				lock_fall_timer = 3;
			end
			prev_adc1_reset = cal_ctrl.adc1_reset;
			if (lock_rise_timer != 0) begin
				lock_rise_timer = lock_rise_timer - 1;
				if (lock_rise_timer == 0) begin
					adc1_locked = 1'b1;
				end
			end
			if (cal_ctrl.adc1_dcm_reset) begin
				lock_rise_timer = 4;
				psen_count = 0; // the DCM restarts at phase zero
			end
			adc1_clk_level = (psen_count >= edge_phase);
		end
	end

	task automatic report_value_error(input test_name_t name, input string what,
			input int expected, input int actual);
		value_errors = value_errors + 1;
		$display("[ERROR] %0s %0s: expected %0d, actual %0d", name, what, expected, actual);
	endtask

	task automatic check_stall();
		int stall_cycles;
		stall_cycles = 0;
		@(negedge dcm_psclk);
		while (sync_state == STALL && stall_cycles < STALL_LIMIT) begin
			if (cal_ctrl != 4'b0001) begin
				report_value_error("startup", "control outputs in stall", 1, int'(cal_ctrl));
			end
			stall_cycles = stall_cycles + 1;
			@(negedge dcm_psclk);
		end
		if (stall_cycles >= STALL_LIMIT) begin
			other_errors = other_errors + 1;
			$display("timeout: the state machine never left the start-up stall");
		end
		if (stall_cycles != int'(`CAL_STALL_CYCLES)) begin
			report_value_error("startup", "stall cycles", int'(`CAL_STALL_CYCLES), stall_cycles);
		end
		if (sync_state != IDLE) begin
			report_value_error("startup", "state after stall", int'(IDLE), int'(sync_state));
		end
	endtask

	task automatic check_idle_hold();
		repeat (8) begin
			@(negedge dcm_psclk);
			if (sync_state != IDLE) begin
				report_value_error("startup", "state while unlocked", int'(IDLE), int'(sync_state));
			end
		end
	endtask

	task automatic run_test(input test_name_t name, input int phase_at, input int exp_peak,
			input logic [`CAL_REC_WIDTH-1:0] exp_entry, output bit aborted);
		int steps;
		int peak;
		int saves;
		int cycles;
		int limit;
		int i;
		int exp_steps;
		int exp_saves;
		bit overflow_run;
		bit finished;
		logic [`CAL_REC_WIDTH*`CAL_REC_DEPTH-1:0] exp_word;
		steps = 0;
		peak = 0;
		saves = 0;
		cycles = 0;
		finished = 1'b0;
		overflow_run = (phase_at > int'(`CAL_PS_MAX)); // the count saturates before the edge
		exp_steps = overflow_run ? int'(`CAL_PS_MAX) : phase_at;
		exp_saves = overflow_run ? 0 : 1;
		limit = (phase_at + 4) * 24 + 100;
		edge_phase = phase_at;
		if (!adc0_locked) begin
			@(posedge dcm_psclk);
			#(DRIVE_DELAY);
			adc0_locked = 1'b1;
		end
		while (!finished && cycles < limit) begin
			@(negedge dcm_psclk);
			cycles = cycles + 1;
			if (cal_ctrl.psen) begin
				steps = steps + 1;
			end
			if (int'(ps_count) > peak) begin
				peak = int'(ps_count);
			end
			if (sync_state == SAVE_PHASE) begin
				saves = saves + 1;
			end
			finished = cal_ctrl.adc1_dcm_reset;
		end
		aborted = !finished;
		if (!finished) begin
			other_errors = other_errors + 1;
			$display("timeout in test %0s: no DCM reset within %0d cycles", name, limit);
		end else begin
			@(negedge dcm_psclk); // the count clears on the edge after the DCM reset pulse
			if (int'(ps_count) != 0) begin
				report_value_error(name, "ps_count after DCM reset", 0, int'(ps_count));
			end
			if (steps != exp_steps) begin
				report_value_error(name, "psen pulses", exp_steps, steps);
			end
			if (peak != exp_peak || peak > int'(`CAL_PS_MAX)) begin
				report_value_error(name, "peak ps_count", exp_peak, peak);
			end
			if (saves != exp_saves) begin
				report_value_error(name, "phase saves", exp_saves, saves);
			end
			if (valid_ps_counts[`CAL_REC_WIDTH-1:0] != exp_entry) begin
				report_value_error(name, "newest record entry", int'(exp_entry),
					int'(valid_ps_counts[`CAL_REC_WIDTH-1:0]));
			end
			if (!overflow_run) begin
				for (i = `CAL_REC_DEPTH - 1; i > 0; i = i - 1) begin
					exp_rec[i] = exp_rec[i-1];
				end
				exp_rec[0] = exp_entry;
			end
			for (i = 0; i < `CAL_REC_DEPTH; i = i + 1) begin
				exp_word[i*`CAL_REC_WIDTH +: `CAL_REC_WIDTH] = exp_rec[i];
			end
			if (valid_ps_counts != exp_word) begin
				value_errors = value_errors + 1;
				$display("[ERROR] %0s record: expected %h, actual %h", name, exp_word,
					valid_ps_counts);
			end
		end
	endtask

	task automatic finish_run(input int tests_run);
		$display("tests run: %0d, value errors: %0d, other errors: %0d",
			tests_run, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	endtask

	initial begin : main_sequence
		int fd;
		int fields;
		int tests_run;
		int phase_at;
		int exp_peak;
		int i;
		bit aborted;
		logic [`CAL_REC_WIDTH-1:0] exp_entry;
		test_name_t name;
		string line;
		void'($urandom(32'h3cad7a47));
		ctrl_reset = 1'b1;
		adc0_locked = 1'b0; // held low to watch the state machine wait in IDLE
		edge_phase = 0;
		value_errors = 0;
		other_errors = 0;
		tests_run = 0;
		aborted = 1'b0;
		for (i = 0; i < `CAL_REC_DEPTH; i = i + 1) begin
			exp_rec[i] = '0;
		end
		repeat (3) @(posedge dcm_psclk);
		#(DRIVE_DELAY);
		ctrl_reset = 1'b0;
		check_stall();
		check_idle_hold();
		fd = $fopen("testbench/adc_cal_tests.txt", "r");
		if (fd == 0) begin
			other_errors = other_errors + 1;
			$display("could not open the test data file");
		end else begin
			while (!aborted && !$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				fields = $sscanf(line, "%s %d %d %h", name, phase_at, exp_peak, exp_entry);
				if (fields == 4) begin // comment and blank lines do not parse
					run_test(name, phase_at, exp_peak, exp_entry, aborted);
					tests_run = tests_run + 1;
				end
			end
			$fclose(fd);
		end
		if (tests_run == 0) begin
			other_errors = other_errors + 1;
			$display("no tests were read from the data file");
		end
		finish_run(tests_run);
	end

endmodule

`default_nettype wire

/* testbench/adc_cal_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_cal_properties (
	input wire dcm_psclk,
	input wire ctrl_reset,
	input wire adc_cal_pkg::cal_state_t sync_state,
	input wire adc_cal_pkg::cal_ctrl_t cal_ctrl,
	input wire phase_save_en
);

	import adc_cal_pkg::*;

	psen_single_cycle: assert property (
		@(posedge dcm_psclk) disable iff (ctrl_reset)
		cal_ctrl.psen |=> !cal_ctrl.psen
	) else $error("psen stayed high for more than one cycle");

	// the DCM reset pulse comes straight out of BEGIN_RESET
	dcm_reset_after_adc_reset: assert property (
		@(posedge dcm_psclk) disable iff (ctrl_reset)
		cal_ctrl.adc1_dcm_reset |-> $past(cal_ctrl.adc1_reset)
	) else $error("adc1_dcm_reset was not preceded by adc1_reset");

	save_after_check_edge: assert property (
		@(posedge dcm_psclk) disable iff (ctrl_reset)
		phase_save_en |-> ($past(sync_state) == CHECK_EDGE)
	) else $error("phase_save_en outside the cycle after CHECK_EDGE");

	psincdec_always_high: assert property (
		@(posedge dcm_psclk)
		cal_ctrl.psincdec
	) else $error("psincdec went low");

endmodule

`default_nettype wire

/* logic/adc_cal_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_cal_defs.svh"

module adc_cal_top (
	input wire dcm_psclk,
	input wire ctrl_reset,
	input wire adc_cal_pkg::dcm_status_t dcm_status,
	input wire adc1_clk_level,
	output adc_cal_pkg::cal_ctrl_t cal_ctrl,
	output adc_cal_pkg::cal_state_t sync_state,
	output logic [`CAL_PS_WIDTH-1:0] ps_count,
	output logic [`CAL_REC_WIDTH*`CAL_REC_DEPTH-1:0] valid_ps_counts
);

	import adc_cal_pkg::*;

	sampler_status_t sampler_status;
	logic ps_overflow;
	logic clk_sample_req;
	logic phase_save_en;

	calibration_fsm calibration_fsm_inst (
		.dcm_psclk(dcm_psclk),
		.ctrl_reset(ctrl_reset),
		.dcm_status(dcm_status),
		.ps_overflow(ps_overflow),
		.sampler_status(sampler_status),
		.sync_state(sync_state),
		.cal_ctrl(cal_ctrl),
		.clk_sample_req(clk_sample_req),
		.phase_save_en(phase_save_en)
	);

	phase_shift_counter phase_shift_counter_inst (
		.dcm_psclk(dcm_psclk),
		.ctrl_reset(ctrl_reset),
		.step(cal_ctrl.psen),
		.clear(cal_ctrl.adc1_dcm_reset),
		.ps_count(ps_count),
		.ps_overflow(ps_overflow)
	);

	clock_edge_sampler clock_edge_sampler_inst (
		.dcm_psclk(dcm_psclk),
		.ctrl_reset(ctrl_reset),
		.sample_req(clk_sample_req),
		.clear(cal_ctrl.adc1_dcm_reset),
		.clk_level(adc1_clk_level),
		.sampler_status(sampler_status)
	);

	// only the low byte of the phase count is kept in the record
	valid_phase_record valid_phase_record_inst (
		.dcm_psclk(dcm_psclk),
		.ctrl_reset(ctrl_reset),
		.save(phase_save_en),
		.phase(ps_count[`CAL_REC_WIDTH-1:0]),
		.valid_ps_counts(valid_ps_counts)
	);

endmodule

`default_nettype wire

/* logic/valid_phase_record.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_cal_defs.svh"

module valid_phase_record (
	input wire dcm_psclk,
	input wire ctrl_reset,
	input wire save,
	input wire [`CAL_REC_WIDTH-1:0] phase,
	output logic [`CAL_REC_WIDTH*`CAL_REC_DEPTH-1:0] valid_ps_counts
);

	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset) begin
			valid_ps_counts <= '0;
		end else if (save) begin
			// oldest entry drops off the top, newest lands in the low byte
			valid_ps_counts <= {
				valid_ps_counts[`CAL_REC_WIDTH*(`CAL_REC_DEPTH-1)-1:0],
				phase
			};
		end
	end

endmodule

`default_nettype wire

/* logic/clock_edge_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_cal_defs.svh"

module clock_edge_sampler (
	input wire dcm_psclk,
	input wire ctrl_reset,
	input wire sample_req,
	input wire clear,
	input wire clk_level,
	output adc_cal_pkg::sampler_status_t sampler_status
);

	logic busy;
	logic prev_vote;
	logic [`CAL_VOTE_WIDTH-1:0] vote_count;
	logic [`CAL_VOTE_WIDTH-1:0] vote_ones;
	logic [`CAL_VOTE_WIDTH-1:0] ones_next;
	logic vote;

	// majority over the samples so far, including the one taken this cycle
	assign ones_next = vote_ones + {{(`CAL_VOTE_WIDTH-1){1'b0}}, clk_level};
	assign vote = (ones_next > (`CAL_VOTE_SAMPLES >> 1));

	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset || clear) begin
			busy <= 1'b0;
			prev_vote <= 1'b1; // first vote after a restart cannot look like an edge
			sampler_status.sample_valid <= 1'b1;
			sampler_status.edge_found <= 1'b0;
		end else if (!busy) begin
			if (sample_req) begin
				busy <= 1'b1;
				sampler_status.sample_valid <= 1'b0;
				sampler_status.edge_found <= 1'b0;
			end
		end else if (vote_count == `CAL_VOTE_SAMPLES - 1'b1) begin
			busy <= 1'b0;
			prev_vote <= vote;
			sampler_status.sample_valid <= 1'b1;
			sampler_status.edge_found <= !prev_vote && vote; // low to high between two steps
		end
	end

	always_ff @(posedge dcm_psclk) begin
		if (!busy) begin
			vote_count <= '0;
			vote_ones <= '0;
		end else begin
			vote_count <= vote_count + 1'b1;
			vote_ones <= ones_next;
		end
	end

endmodule

`default_nettype wire

/* logic/phase_shift_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_cal_defs.svh"

module phase_shift_counter (
	input wire dcm_psclk,
	input wire ctrl_reset,
	input wire step,
	input wire clear,
	output logic [`CAL_PS_WIDTH-1:0] ps_count,
	output logic ps_overflow
);

	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset) begin
			ps_count <= '0;
		end else if (clear) begin
			ps_count <= '0; // the DCM restarts from phase zero
		end else if (step && ps_count != `CAL_PS_MAX) begin
			ps_count <= ps_count + 1'b1;
		end
	end

	// stays up until the next DCM reset clears the count
	assign ps_overflow = (ps_count == `CAL_PS_MAX);

endmodule

`default_nettype wire

/* logic/calibration_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_cal_defs.svh"

module calibration_fsm (
	input wire dcm_psclk,
	input wire ctrl_reset,
	input wire adc_cal_pkg::dcm_status_t dcm_status,
	input wire ps_overflow,
	input wire adc_cal_pkg::sampler_status_t sampler_status,
	output adc_cal_pkg::cal_state_t sync_state,
	output adc_cal_pkg::cal_ctrl_t cal_ctrl,
	output logic clk_sample_req,
	output logic phase_save_en
);

	import adc_cal_pkg::*;

	cal_state_t next_state;
	logic [`CAL_STALL_WIDTH-1:0] stall_count;

	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset) begin
			stall_count <= '0;
		end else if (sync_state == STALL) begin
			stall_count <= stall_count + 1'b1; // only runs once, right after reset
		end
	end

	always_ff @(posedge dcm_psclk) begin
		if (ctrl_reset) begin
			sync_state <= STALL;
		end else begin
			sync_state <= next_state;
		end
	end

	always_comb begin
		cal_ctrl = '0;
		cal_ctrl.psincdec = 1'b1; // the sweep only ever moves forward
		clk_sample_req = 1'b0;
		phase_save_en = 1'b0;
		next_state = sync_state;

		case (sync_state)
			STALL: begin
				if (stall_count == `CAL_STALL_CYCLES - 1'b1) begin
					next_state = IDLE;
				end
			end

			IDLE: begin
				if (ps_overflow) begin
					next_state = BEGIN_RESET; // ran off the end without an edge
				end else if (dcm_status.adc0_locked && dcm_status.adc1_locked) begin
					next_state = SHIFT;
				end
			end

			SHIFT: begin
				cal_ctrl.psen = 1'b1;
				next_state = WAIT_PSDONE;
			end

			WAIT_PSDONE: begin
				if (dcm_status.psdone) begin
					next_state = SAMPLE;
				end
			end

			SAMPLE: begin
				clk_sample_req = 1'b1; // held until the sampler drops sample_valid
				if (!sampler_status.sample_valid) begin
					next_state = WAIT_SAMPLE;
				end
			end

			WAIT_SAMPLE: begin
				if (sampler_status.sample_valid) begin
					next_state = CHECK_EDGE;
				end
			end

			CHECK_EDGE: begin
				if (sampler_status.edge_found) begin
					next_state = SAVE_PHASE;
				end else begin
					next_state = IDLE; // overflow is looked at there before the next step
				end
			end

			SAVE_PHASE: begin
				phase_save_en = 1'b1;
				next_state = BEGIN_RESET;
			end

			BEGIN_RESET: begin
				cal_ctrl.adc1_reset = 1'b1;
				if (!dcm_status.adc1_locked) begin
					next_state = RESET_DCM;
				end
			end

			RESET_DCM: begin
				cal_ctrl.adc1_dcm_reset = 1'b1; // also clears the phase count and the stored vote
				next_state = IDLE;
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/adc_cal_pkg.sv */
`default_nettype none

package adc_cal_pkg;

	typedef enum logic [3:0] {
		STALL,
		IDLE,
		SHIFT,
		WAIT_PSDONE,
		SAMPLE,
		WAIT_SAMPLE,
		CHECK_EDGE,
		SAVE_PHASE,
		BEGIN_RESET,
		RESET_DCM
	} cal_state_t;

	typedef struct packed {
		logic adc0_locked;
		logic adc1_locked;
		logic psdone; // one-cycle pulse from the second DCM
	} dcm_status_t;

	typedef struct packed {
		logic adc1_reset;
		logic adc1_dcm_reset;
		logic psen;
		logic psincdec;
	} cal_ctrl_t;

	typedef struct packed {
		logic sample_valid;
		logic edge_found; // only meaningful while sample_valid is high
	} sampler_status_t;

endpackage

`default_nettype wire

/* logic/adc_cal_defs.svh */
`ifndef ADC_CAL_DEFS_SVH
`define ADC_CAL_DEFS_SVH

// phase count and its saturation point
`define CAL_PS_WIDTH 10
`define CAL_PS_MAX 10'd600

// record of recent valid phases, one byte per entry
`define CAL_REC_WIDTH 8
`define CAL_REC_DEPTH 16

// start-up stall before the lock check
`define CAL_STALL_WIDTH 5
`define CAL_STALL_CYCLES 5'd16

// clock-level vote, the sample count must stay odd
`define CAL_VOTE_WIDTH 3
`define CAL_VOTE_SAMPLES 3'd5

`endif
